/* dsp_sub.f */
verilog/dsp_bus_pkg.sv
verilog/dsp_irq_pkg.sv
verilog/host_port.sv
verilog/local_ram.sv
verilog/divide_unit.sv
verilog/irq_cond.sv
verilog/dsp_ctrl.sv
verilog/dsp_sub.sv
bench/tb_dsp_sub.sv

/* Bender.yml */
package:
  name: dsp_sub

sources:
  - files:
      - verilog/dsp_bus_pkg.sv
      - verilog/dsp_irq_pkg.sv
      - verilog/host_port.sv
      - verilog/local_ram.sv
      - verilog/divide_unit.sv
      - verilog/irq_cond.sv
      - verilog/dsp_ctrl.sv
      - verilog/dsp_sub.sv
  - target: test
    files:
      - bench/tb_dsp_sub.sv

/* bench/tb_dsp_sub.sv */
//----------------------------------------------------------------------------
// Random self-checking testbench for the DSP subsystem, fixed seed of 8.
// Host strobes are kept at least 4 cycles apart, outputs sampled on the
// falling edge. A watchdog bounds the run by the number of planned operations.
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_dsp_sub;
	import dsp_bus_pkg::*;
	import dsp_irq_pkg::*;

	localparam int n_ram       = 64;	// Random RAM writes
	localparam int n_div       = 22;	// 20 random pairs plus two corner cases
	localparam int n_rounds    = 6;	// Interrupt rounds
	localparam int planned_ops = 4 + 2 * n_ram + 1 + 10 * n_div + 8 + 9 * n_rounds;

	logic       sys_clk = 1'b0;
	logic       rst;
	logic [10:0] io_addr;
	logic       io_wr;
	logic       io_rd;
	half_t      io_wdata;
	logic [1:0] eint_n;
	logic [1:0] tint;
	logic       i2int;
	half_t      io_rdata;
	logic       io_rvalid;
	logic       cpu_int;
	logic       irq_pending;

	integer   seed = 8;
	word_t    ram_model [ram_words];	// Expected RAM contents
	bit       ram_touched [ram_words];
	irq_vec_t latch_m;	// Expected interrupt latch
	irq_vec_t mask_m;

	always #20 sys_clk = ~sys_clk;	// 40 ns period

	dsp_sub i_dsp_sub
	(
		.sys_clk     (sys_clk),
		.rst         (rst),
		.io_addr     (io_addr),
		.io_wr       (io_wr),
		.io_rd       (io_rd),
		.io_wdata    (io_wdata),
		.eint_n      (eint_n),
		.tint        (tint),
		.i2int       (i2int),
		.io_rdata    (io_rdata),
		.io_rvalid   (io_rvalid),
		.cpu_int     (cpu_int),
		.irq_pending (irq_pending)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_irq(input string name, input irq_vec_t exp, input irq_vec_t act);
		if (act !== exp)
			abort_run($sformatf("Error %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_level(input string name, input bit exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Error %s: expected %b, actual %b", name, exp, act));
	endtask

	// One host strobe, one cycle wide
	task automatic drive_half(input bit w, input bit r, input word_addr_t a, input bit hi,
		input half_t d);
		@(posedge sys_clk);
		io_addr  <= {a, hi};
		io_wr    <= w;
		io_rd    <= r;
		io_wdata <= d;
		@(posedge sys_clk);
		io_wr <= 1'b0;
		io_rd <= 1'b0;
	endtask

	task automatic wait_rvalid(output half_t h);
		int n;
		bit got;
		got = 1'b0;
		for (n = 0; n < 8 && !got; n++)
		begin
			@(negedge sys_clk);
			got = io_rvalid;
		end
		if (!got)
			abort_run("Host port gave no read response within 8 cycles");
		h = io_rdata;
	endtask

	task automatic idle();
		repeat (4) @(posedge sys_clk);	// Keeps the strobe spacing
	endtask

	task automatic host_write32(input word_addr_t a, input word_t d);
		drive_half(1'b1, 1'b0, a, 1'b0, d[15:0]);	// Held in the port
		idle();
		drive_half(1'b1, 1'b0, a, 1'b1, d[31:16]);	// Commits the word
		idle();
	endtask

	task automatic host_read32(input word_addr_t a, output word_t d);
		half_t lo;
		half_t hi;
		drive_half(1'b0, 1'b1, a, 1'b0, '0);	// Fetches the whole word
		wait_rvalid(lo);
		idle();
		drive_half(1'b0, 1'b1, a, 1'b1, '0);	// Upper half from the hold register
		wait_rvalid(hi);
		idle();
		d = {hi, lo};
	endtask

	task automatic run_division(input word_t dvsr, input word_t dvnd);
		word_t st;
		word_t q;
		word_t r;
		int    polls;
		host_write32(div_dvsr_addr, dvsr);
		host_write32(div_dvnd_addr, dvnd);	// Starts the run
		polls = 0;
		st    = 32'd1;
		while (st[0])
		begin
			if (polls == 10)
				abort_run("Divider still busy after 10 status polls");
			host_read32(div_stat_addr, st);
			polls++;
		end
		check_word("div status", '0, st);
		host_read32(div_dvsr_addr, q);
		host_read32(div_dvnd_addr, r);
		// Zero divisor gives all ones and the dividend back
		check_word("div quotient", (dvsr == '0) ? '1 : dvnd / dvsr, q);
		check_word("div remainder", (dvsr == '0) ? dvnd : dvnd % dvsr, r);
	endtask

	// Line pattern p is i2int, tint 0, tint 1, ext 0, ext 1
	task automatic pulse_lines(input logic [4:0] p);
		@(posedge sys_clk);
		i2int  <= p[0];
		tint   <= p[2:1];
		eint_n <= ~p[4:3];
		repeat (2) @(posedge sys_clk);
		i2int  <= 1'b0;
		tint   <= 2'b00;
		eint_n <= 2'b11;
		repeat (6) @(posedge sys_clk);	// Synchronizer, edge and latch settle
	endtask

	function automatic irq_vec_t lines_to_irq(input logic [4:0] p);
		irq_vec_t v;
		v           = '0;
		v[irq_i2s]  = p[0];
		v[irq_tim0] = p[1];
		v[irq_tim1] = p[2];
		v[irq_ext0] = p[3];
		v[irq_ext1] = p[4];
		return v;
	endfunction

	initial
	begin
		repeat (planned_ops * 100) @(posedge sys_clk);
		abort_run("Watchdog expired, the run hung before all tests finished");
	end

	initial
	begin
		word_t      d;
		word_t      rnd;
		word_t      dvsr;
		word_addr_t a;
		irq_vec_t   clr;
		bit         sw;
		rst      <= 1'b1;
		io_addr  <= '0;
		io_wr    <= 1'b0;
		io_rd    <= 1'b0;
		io_wdata <= '0;
		eint_n   <= 2'b11;	// Inactive
		tint     <= 2'b00;
		i2int    <= 1'b0;
		latch_m  = '0;
		mask_m   = '0;
		repeat (16) @(posedge sys_clk);
		rst <= 1'b0;
		idle();

		// Reset state
		@(negedge sys_clk);
		check_level("reset cpu_int", 1'b0, cpu_int);
		check_level("reset irq_pending", 1'b0, irq_pending);
		host_read32(ctrl_addr, d);
		check_word("reset ctrl word", '0, d);
		host_read32(irq_addr, d);
		check_word("reset irq word", '0, d);
		host_read32(div_stat_addr, d);
		check_word("reset div status", '0, d);

		// Local RAM
		for (int i = 0; i < n_ram; i++)
		begin
			rnd = $random(seed);
			a   = word_addr_t'(rnd[ram_addr_bits-1:0]);
			d   = $random(seed);
			host_write32(a, d);
			ram_model[a]   = d;
			ram_touched[a] = 1'b1;
		end
		for (int i = 0; i < ram_words; i++)
			if (ram_touched[i])
			begin
				host_read32(word_addr_t'(i), d);
				check_word($sformatf("ram word %0h", i), ram_model[i], d);
			end
		host_read32(10'h200, d);
		check_word("unmapped read", '0, d);

		// Random divider pairs with divisors of random size
		for (int i = 0; i < n_div - 2; i++)
		begin
			rnd  = $random(seed);
			dvsr = $random(seed);
			d    = $random(seed);
			run_division(dvsr >> rnd[4:0], d);
		end
		run_division('0, $random(seed));
		run_division(32'd1, $random(seed));

		// Go and cpu_int bits of the control word
		for (int i = 0; i < 4; i++)
		begin
			host_write32(ctrl_addr, word_t'(i));
			@(negedge sys_clk);
			check_level("cpu_int output", i[1], cpu_int);
			host_read32(ctrl_addr, d);
			check_word("ctrl readback", word_t'(i), d);
		end

		// Interrupt latch, mask, software strobe and clear
		for (int r = 0; r < n_rounds; r++)
		begin
			rnd = $random(seed);
			pulse_lines(rnd[4:0]);
			latch_m = latch_m | lines_to_irq(rnd[4:0]);
			host_read32(irq_addr, d);
			check_irq("irq latch after pulse", latch_m, d[irq_count-1:0]);
			mask_m = rnd[13:8];
			sw     = rnd[16];
			host_write32(ctrl_addr, (word_t'(mask_m) << 8) | (word_t'(sw) << 2));
			if (sw)
				latch_m[irq_sw] = 1'b1;
			@(negedge sys_clk);
			check_level("irq_pending vs mask", |(latch_m & mask_m), irq_pending);
			host_read32(ctrl_addr, d);
			check_word("ctrl mask readback", word_t'(mask_m) << 8, d);	// Strobe reads 0
			host_read32(irq_addr, d);
			check_irq("irq latch after sw strobe", latch_m, d[irq_count-1:0]);
			clr = rnd[29:24];
			host_write32(irq_addr, word_t'(clr));
			latch_m = latch_m & ~clr;
			host_read32(irq_addr, d);
			check_irq("irq latch after clear", latch_m, d[irq_count-1:0]);
			@(negedge sys_clk);
			check_level("irq_pending after clear", |(latch_m & mask_m), irq_pending);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* verilog/dsp_sub.sv */
//----------------------------------------------------------------------------
// Host-visible DSP subsystem top. Host port drives one internal bus to
// the RAM, divider and control unit. Read returns are ORed by enable.
// Everything runs on sys_clk with a synchronous active-high reset.
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module dsp_sub
(
	input  logic               sys_clk,
	input  logic               rst,
	input  logic [10:0]        io_addr,
	input  logic               io_wr,
	input  logic               io_rd,
	input  dsp_bus_pkg::half_t io_wdata,
	input  logic [1:0]         eint_n,
	input  logic [1:0]         tint,
	input  logic               i2int,
	output dsp_bus_pkg::half_t io_rdata,
	output logic               io_rvalid,
	output logic               cpu_int,
	output logic               irq_pending
);
	import dsp_bus_pkg::*;
	import dsp_irq_pkg::*;

	reg_wr_t  wr;
	reg_rd_t  rd;
	rd_ret_t  ram_ret;
	rd_ret_t  div_ret;
	rd_ret_t  ctrl_ret;
	rd_ret_t  rd_merged;
	irq_vec_t events;

	// At most one peer answers so the returns merge by OR
	assign rd_merged.oe   = ram_ret.oe | div_ret.oe | ctrl_ret.oe;
	assign rd_merged.data = (ram_ret.oe ? ram_ret.data : '0)
		| (div_ret.oe ? div_ret.data : '0)
		| (ctrl_ret.oe ? ctrl_ret.data : '0);

	host_port i_host_port
	(
		.sys_clk   (sys_clk),
		.rst       (rst),
		.io_addr   (io_addr),
		.io_wr     (io_wr),
		.io_rd     (io_rd),
		.io_wdata  (io_wdata),
		.rd_merged (rd_merged),
		.wr        (wr),
		.rd        (rd),
		.io_rdata  (io_rdata),
		.io_rvalid (io_rvalid)
	);

	local_ram i_local_ram
	(
		.sys_clk (sys_clk),
		.wr      (wr),
		.rd      (rd),
		.ret     (ram_ret)
	);

	divide_unit i_divide_unit
	(
		.sys_clk (sys_clk),
		.rst     (rst),
		.wr      (wr),
		.rd      (rd),
		.ret     (div_ret)
	);

	irq_cond i_irq_cond
	(
		.sys_clk (sys_clk),
		.rst     (rst),
		.eint_n  (eint_n),
		.tint    (tint),
		.i2int   (i2int),
		.events  (events)
	);

	dsp_ctrl i_dsp_ctrl
	(
		.sys_clk     (sys_clk),
		.rst         (rst),
		.wr          (wr),
		.rd          (rd),
		.events      (events),
		.ret         (ctrl_ret),
		.cpu_int     (cpu_int),
		.irq_pending (irq_pending)
	);

endmodule

/* verilog/dsp_ctrl.sv */
//----------------------------------------------------------------------------
// Control and interrupt unit. Control word holds go, cpu_int, the software
// interrupt strobe and the mask. The irq word reads the latch and clears
// it by writing ones. A new event wins over a clear in the same cycle.
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module dsp_ctrl
(
	input  logic                  sys_clk,
	input  logic                  rst,
	input  dsp_bus_pkg::reg_wr_t  wr,
	input  dsp_bus_pkg::reg_rd_t  rd,
	input  dsp_irq_pkg::irq_vec_t events,
	output dsp_bus_pkg::rd_ret_t  ret,
	output logic                  cpu_int,	// Level to the host CPU
	output logic                  irq_pending
);
	import dsp_bus_pkg::*;
	import dsp_irq_pkg::*;

	logic     go;
	irq_vec_t mask;
	irq_vec_t latch;
	irq_vec_t sw_set;	// Software strobe into bit 0
	irq_vec_t clr;	// Write-one-to-clear bits
	logic     ctrl_wr;
	logic     irq_wr;
	logic     ctrl_rd;
	logic     irq_rd;
	word_t    ctrl_word;

	assign ctrl_wr = wr.stb && (wr.addr == ctrl_addr);
	assign irq_wr  = wr.stb && (wr.addr == irq_addr);
	assign ctrl_rd = rd.stb && (rd.addr == ctrl_addr);
	assign irq_rd  = rd.stb && (rd.addr == irq_addr);

	always_comb
	begin
		sw_set         = '0;
		sw_set[irq_sw] = ctrl_wr & wr.data[2];
	end

	assign clr = irq_wr ? wr.data[irq_count-1:0] : '0;

	// Mask sits in 13:8 and strobe bit 2 always reads 0
	assign ctrl_word = {18'b0, mask, 6'b0, cpu_int, go};

	assign irq_pending = |(latch & mask);

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			go      <= 1'b0;
			cpu_int <= 1'b0;
			mask    <= '0;
			latch   <= '0;
			ret.oe  <= 1'b0;
		end
		else
		begin
			if (ctrl_wr)
			begin
				go      <= wr.data[0];
				cpu_int <= wr.data[1];
				mask    <= wr.data[13:8];
			end
			latch  <= (latch & ~clr) | events | sw_set;	// Set after clear
			ret.oe <= ctrl_rd | irq_rd;
		end

		ret.data <= irq_rd ? word_t'(latch) : ctrl_word;
	end

	// Bit 0 belongs to the software strobe and never arrives as an event
	assert property (@(posedge sys_clk) disable iff (rst)
		!events[irq_sw])
		else $error("dsp_ctrl: software bit set in the event vector");

endmodule

/* verilog/irq_cond.sv */
//----------------------------------------------------------------------------
// Interrupt conditioner. Two synchronizer stages on every line.
// External and serial lines give a one-cycle event on assertion,
// timer lines pass through as levels. Input to event is 3 cycles.
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module irq_cond
(
	input  logic                  sys_clk,
	input  logic                  rst,
	input  logic [1:0]            eint_n,	// Active low
	input  logic [1:0]            tint,
	input  logic                  i2int,
	output dsp_irq_pkg::irq_vec_t events
);
	import dsp_irq_pkg::*;

	irq_vec_t raw;	// Lines gathered active high
	irq_vec_t sync1;
	irq_vec_t sync2;
	irq_vec_t last;	// sync2 one cycle back, for edges

	always_comb
	begin
		raw                     = '0;	// Software bit comes from the control unit
		raw[irq_i2s]            = i2int;
		raw[irq_tim1:irq_tim0]  = tint;
		raw[irq_ext1:irq_ext0]  = ~eint_n;
	end

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			sync1  <= '0;
			sync2  <= '0;
			last   <= '0;
			events <= '0;
		end
		else
		begin
			sync1  <= raw;
			sync2  <= sync1;
			last   <= sync2;
			events <= (sync2 & ~last & irq_edge_mask)	// Rising edges
				| (sync2 & ~irq_edge_mask);		// Levels
		end
	end

endmodule

/* verilog/divide_unit.sv */
//----------------------------------------------------------------------------
// Iterative unsigned 32/32 divider, restoring, one quotient bit per cycle.
// Writing the dividend starts a run of 33 cycles with busy high.
// A zero divisor gives a quotient of all ones and the dividend as remainder.
// Operand writes while busy are dropped.
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module divide_unit
(
	input  logic                 sys_clk,
	input  logic                 rst,
	input  dsp_bus_pkg::reg_wr_t wr,
	input  dsp_bus_pkg::reg_rd_t rd,
	output dsp_bus_pkg::rd_ret_t ret
);
	import dsp_bus_pkg::*;

	word_t       dvsr;	// Divisor
	word_t       quo;	// Dividend shifts out as quotient shifts in
	word_t       rem;	// Partial remainder
	logic [5:0]  cnt;	// 0 to 31 are steps, 32 is the finish cycle
	logic        busy;
	logic [32:0] shifted;	// Remainder with next dividend bit
	logic [32:0] trial;	// Trial subtraction
	logic        dvsr_zero;
	logic        q_bit;
	logic        wr_dvsr;
	logic        wr_dvnd;
	logic        rd_hit;

	assign wr_dvsr = wr.stb && (wr.addr == div_dvsr_addr);
	assign wr_dvnd = wr.stb && (wr.addr == div_dvnd_addr);
	assign rd_hit  = rd.stb && ((rd.addr == div_dvsr_addr) ||
		(rd.addr == div_dvnd_addr) || (rd.addr == div_stat_addr));

	assign shifted   = {rem, quo[31]};
	assign trial     = shifted - {1'b0, dvsr};
	assign dvsr_zero = (dvsr == '0);
	assign q_bit     = ~trial[32] | dvsr_zero;	// Zero divisor always subtracts nothing

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			cnt  <= '0;
		end
		else if (busy)
		begin
			cnt <= cnt + 6'd1;
			if (cnt == 6'd32)
				busy <= 1'b0;	// Result settled
		end
		else if (wr_dvnd)
		begin
			busy <= 1'b1;
			cnt  <= '0;
		end

		// Operand load and shift-subtract steps
		if (!busy)
		begin
			if (wr_dvsr)
				dvsr <= wr.data;
			if (wr_dvnd)
			begin
				quo <= wr.data;
				rem <= '0;
			end
		end
		else if (!cnt[5])
		begin
			quo <= {quo[30:0], q_bit};
			rem <= q_bit ? trial[31:0] : shifted[31:0];	// Restore on borrow
		end
	end

	// Read returns
	always_ff @(posedge sys_clk)
	begin
		if (rst)
			ret.oe <= 1'b0;
		else
			ret.oe <= rd_hit;

		case (rd.addr)
			div_dvsr_addr: ret.data <= quo;
			div_dvnd_addr: ret.data <= rem;
			default:       ret.data <= word_t'(busy);	// Status word
		endcase
	end

	// Software must wait for busy to drop before loading new operands
	assert property (@(posedge sys_clk) disable iff (rst)
		busy |-> !(wr_dvsr || wr_dvnd))
		else $error("divide_unit: operand write while busy");

endmodule

/* verilog/local_ram.sv */
//----------------------------------------------------------------------------
// Local work RAM, 256 words of 32 bits on the internal bus.
// Word addresses below ram_words select it.
// Contents are undefined after reset.
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module local_ram
(
	input  logic                 sys_clk,
	input  dsp_bus_pkg::reg_wr_t wr,
	input  dsp_bus_pkg::reg_rd_t rd,
	output dsp_bus_pkg::rd_ret_t ret
);
	import dsp_bus_pkg::*;

	word_t mem [ram_words];
	logic  wr_hit;
	logic  rd_hit;

	assign wr_hit = wr.stb && (wr.addr < ram_words);
	assign rd_hit = rd.stb && (rd.addr < ram_words);

	// Synchronous read, data one cycle after the strobe
	always_ff @(posedge sys_clk)
	begin
		if (wr_hit)
			mem[wr.addr[ram_addr_bits-1:0]] <= wr.data;
		ret.oe   <= rd_hit;
		ret.data <= mem[rd.addr[ram_addr_bits-1:0]];
	end

endmodule

/* verilog/host_port.sv */
//----------------------------------------------------------------------------
// Host port. 16-bit halves in, 32-bit internal bus cycles out.
// A low-half write is held until the high-half write commits the word.
// A low-half read fetches the word, a high-half read returns the held
// upper half. Host strobes must be at least 4 cycles apart.
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module host_port
(
	input  logic                 sys_clk,
	input  logic                 rst,
	input  logic [10:0]          io_addr,	// Bit 0 picks the half
	input  logic                 io_wr,
	input  logic                 io_rd,
	input  dsp_bus_pkg::half_t   io_wdata,
	input  dsp_bus_pkg::rd_ret_t rd_merged,	// ORed peer returns
	output dsp_bus_pkg::reg_wr_t wr,
	output dsp_bus_pkg::reg_rd_t rd,
	output dsp_bus_pkg::half_t   io_rdata,
	output logic                 io_rvalid
);
	import dsp_bus_pkg::*;

	word_addr_t io_word;	// Word part of the host address
	logic       io_hi;
	half_t      lo_hold;	// Low write half awaiting its partner
	half_t      hi_hold;	// Upper half of the last fetched word
	logic       rd_wait;	// Peer return expected this cycle

	assign io_word = io_addr[10:1];
	assign io_hi   = io_addr[0];

	always_ff @(posedge sys_clk)
	begin
		if (rst)
		begin
			wr.stb    <= 1'b0;
			rd.stb    <= 1'b0;
			rd_wait   <= 1'b0;
			io_rvalid <= 1'b0;
		end
		else
		begin
			wr.stb    <= io_wr & io_hi;	// Only the high half commits
			rd.stb    <= io_rd & ~io_hi;	// Only the low half fetches
			rd_wait   <= rd.stb;
			io_rvalid <= rd_wait | (io_rd & io_hi);
		end

		// Data path
		if (io_wr & ~io_hi)
			lo_hold <= io_wdata;
		if (io_wr & io_hi)
		begin
			wr.addr <= io_word;
			wr.data <= {io_wdata, lo_hold};
		end
		if (io_rd & ~io_hi)
			rd.addr <= io_word;

		if (rd_wait)
		begin
			// Unmapped addresses merge to zero
			io_rdata <= rd_merged.data[15:0];
			hi_hold  <= rd_merged.data[31:16];
		end
		else if (io_rd & io_hi)
			io_rdata <= hi_hold;	// No bus cycle for the high half
	end

	// Peers answer only the read this port put on the bus two cycles ago
	assert property (@(posedge sys_clk) disable iff (rst)
		rd_merged.oe |-> rd_wait)
		else $error("host_port: read return with no outstanding read");

endmodule

/* verilog/dsp_irq_pkg.sv */
//----------------------------------------------------------------------------
// Interrupt sources of the DSP subsystem.
// Six sources in one vector. The serial and external lines are
// edge-detected, the timer lines are passed on as levels.
//----------------------------------------------------------------------------
package dsp_irq_pkg;

	localparam int irq_count = 6;

	typedef logic [irq_count-1:0] irq_vec_t;

	// Bit positions in irq_vec_t
	localparam int irq_sw   = 0;	// Host software strobe
	localparam int irq_i2s  = 1;	// Serial interface
	localparam int irq_tim0 = 2;
	localparam int irq_tim1 = 3;
	localparam int irq_ext0 = 4;	// External lines, active low at the pins
	localparam int irq_ext1 = 5;

	// Sources that fire once per rising edge
	localparam irq_vec_t irq_edge_mask = 6'b110010;

endpackage

/* verilog/dsp_bus_pkg.sv */
//----------------------------------------------------------------------------
// Internal register bus of the DSP subsystem.
// 32-bit words on a 10-bit word address and 16-bit host halves.
// The bus is a plain strobe with no handshake. A peer answers one cycle
// after a read strobe, and unmapped addresses get no answer.
//----------------------------------------------------------------------------
package dsp_bus_pkg;

	localparam int word_bits = 32;	// Internal data word
	localparam int half_bits = 16;	// Host port half
	localparam int addr_bits = 10;	// Word address

	typedef logic [word_bits-1:0] word_t;
	typedef logic [half_bits-1:0] half_t;
	typedef logic [addr_bits-1:0] word_addr_t;

	// Local RAM sits at the bottom of the map
	localparam int ram_words     = 256;
	localparam int ram_addr_bits = $clog2(ram_words);

	// Control unit registers
	localparam word_addr_t ctrl_addr     = 10'h100;
	localparam word_addr_t irq_addr      = 10'h101;

	// Divider registers
	localparam word_addr_t div_dvsr_addr = 10'h110;	// Divisor in, quotient out
	localparam word_addr_t div_dvnd_addr = 10'h111;	// Dividend in and start, remainder out
	localparam word_addr_t div_stat_addr = 10'h112;	// Busy in bit 0

	// One write cycle, 43 bits
	typedef struct packed {
		logic       stb;
		word_addr_t addr;
		word_t      data;
	} reg_wr_t;

	// One read request, 11 bits
	typedef struct packed {
		logic       stb;
		word_addr_t addr;
	} reg_rd_t;

	// Read return from one peer, 33 bits
	typedef struct packed {
		logic  oe;	// High for the single return cycle
		word_t data;
	} rd_ret_t;

endpackage
